// File: vlog.f
+incdir+.
csr_pkg.sv
csr_op_unit.sv
csr_regfile.sv
trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_csr_unit
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module tb_csr_unit;

    localparam int CYCLE_LIMIT = 2000;     // well above the full test length

    logic               clk;
    logic               nrst;
    logic               csr_valid;
    csr_pkg::csr_op_t   csr_op;
    logic [11:0]        csr_addr;
    logic [31:0]        csr_src;
    logic               exc_valid;
    logic [30:0]        exc_cause;
    logic [31:0]        exc_pc;
    logic               mret_valid;
    logic               ext_irq;
    logic               timer_irq;
    logic [31:0]        csr_rdata;
    logic               csr_illegal;
    logic               redirect_valid;
    logic [31:0]        redirect_pc;
    csr_pkg::mode_t     current_mode;

    integer seed = 32'hb150_13bb;
    int     err_count = 0;
    int     access_count = 0;
    int     redirect_count = 0;
    int     cycle_count = 0;

    // reference model state
    logic [31:0] m_scratch;
    logic [31:0] m_tvec;
    logic [31:0] m_epc;
    logic [31:0] m_cause;
    logic        m_mie;
    logic        m_mpie;
    logic [1:0]  m_mpp;
    logic [1:0]  m_mode;
    logic        m_meie;
    logic        m_mtie;
    logic        exp_rv;
    logic [31:0] exp_rpc;

    logic        m_ro;
    logic        m_ext_fire;
    logic        m_timer_fire;
    logic        m_trap;
    logic        m_ret;
    logic [31:0] m_cause_next;
    logic [31:0] m_new;
    logic [31:0] exp_rdata;

    csr_unit UUT (
        .clk            (clk),
        .nrst           (nrst),
        .csr_valid      (csr_valid),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_src        (csr_src),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .mret_valid     (mret_valid),
        .ext_irq        (ext_irq),
        .timer_irq      (timer_irq),
        .csr_rdata      (csr_rdata),
        .csr_illegal    (csr_illegal),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .current_mode   (current_mode)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // reference model
    always_comb begin
        case (csr_addr)
            `CSR_MISA:     exp_rdata = `MISA_VALUE;
            `CSR_MSTATUS:  exp_rdata = {19'b0, m_mpp, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
            `CSR_MIE:      exp_rdata = {20'b0, m_meie, 3'b0, m_mtie, 7'b0};
            `CSR_MIP:      exp_rdata = {20'b0, ext_irq, 3'b0, timer_irq, 7'b0};
            `CSR_MTVEC:    exp_rdata = m_tvec;
            `CSR_MEPC:     exp_rdata = m_epc;
            `CSR_MCAUSE:   exp_rdata = m_cause;
            `CSR_MSCRATCH: exp_rdata = m_scratch;
            default:       exp_rdata = '0;     // id regs, unwritten mtval, unimplemented
        endcase
        case (csr_op)
            csr_pkg::OP_WRITE: m_new = csr_src;
            csr_pkg::OP_SET:   m_new = exp_rdata | csr_src;
            default:           m_new = exp_rdata & ~csr_src;
        endcase
    end

    assign m_ro         = (csr_addr[11:10] == 2'b11) || (csr_addr == `CSR_MISA);
    assign m_ext_fire   = ext_irq && m_meie && m_mie;
    assign m_timer_fire = timer_irq && m_mtie && m_mie;
    assign m_ret        = mret_valid && !exc_valid;
    assign m_trap       = exc_valid || (!mret_valid && (m_ext_fire || m_timer_fire));
    assign m_cause_next = exc_valid  ? {1'b0, exc_cause} :
                          m_ext_fire ? {1'b1, csr_pkg::CAUSE_M_EXT} :
                                       {1'b1, csr_pkg::CAUSE_M_TIMER};

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            m_scratch <= '0;
            m_tvec    <= '0;
            m_epc     <= '0;
            m_cause   <= '0;
            m_mie     <= 1'b0;
            m_mpie    <= 1'b0;
            m_mpp     <= 2'd0;
            m_mode    <= 2'd3;
            m_meie    <= 1'b0;
            m_mtie    <= 1'b0;
            exp_rv    <= 1'b0;
            exp_rpc   <= '0;
        end else begin
            exp_rv  <= m_trap || m_ret;
            exp_rpc <= m_ret ? m_epc : m_tvec;
            if (m_trap) begin
                m_epc   <= exc_pc & ~32'h3;
                m_cause <= m_cause_next;
                m_mpie  <= m_mie;
                m_mie   <= 1'b0;
                m_mpp   <= m_mode;
                m_mode  <= 2'd3;
            end else if (m_ret) begin
                m_mie  <= m_mpie;
                m_mpie <= 1'b1;
                m_mode <= m_mpp;
                m_mpp  <= 2'd0;
            end else if (csr_valid && !m_ro) begin
                case (csr_addr)
                    `CSR_MSTATUS: begin
                        m_mie  <= m_new[3];
                        m_mpie <= m_new[7];
                        m_mpp  <= m_new[12:11];    // stimulus only writes U or M
                    end
                    `CSR_MIE: begin
                        m_meie <= m_new[11];
                        m_mtie <= m_new[7];
                    end
                    `CSR_MTVEC:    m_tvec    <= m_new & ~32'h3;
                    `CSR_MEPC:     m_epc     <= m_new & ~32'h3;
                    `CSR_MCAUSE:   m_cause   <= m_new;
                    `CSR_MSCRATCH: m_scratch <= m_new;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // checks
    a_rdata: assert property (@(posedge clk) disable iff (!nrst)
        csr_valid |-> csr_rdata == exp_rdata)
        else begin
            err_count = err_count + 1;
            $display("FAILED csr_rdata at addr %h: got %h expected %h",
                     $sampled(csr_addr), $sampled(csr_rdata), $sampled(exp_rdata));
        end

    a_illegal: assert property (@(posedge clk) disable iff (!nrst)
        csr_illegal == (csr_valid && m_ro))
        else begin
            err_count = err_count + 1;
            $display("FAILED csr_illegal at addr %h: got %h expected %h",
                     $sampled(csr_addr), $sampled(csr_illegal),
                     $sampled(csr_valid && m_ro));
        end

    a_redirect_valid: assert property (@(posedge clk) disable iff (!nrst)
        redirect_valid == exp_rv)
        else begin
            err_count = err_count + 1;
            $display("FAILED redirect_valid: got %h expected %h",
                     $sampled(redirect_valid), $sampled(exp_rv));
        end

    a_redirect_pc: assert property (@(posedge clk) disable iff (!nrst)
        redirect_valid |-> redirect_pc == exp_rpc)
        else begin
            err_count = err_count + 1;
            $display("FAILED redirect_pc: got %h expected %h",
                     $sampled(redirect_pc), $sampled(exp_rpc));
        end

    a_mode: assert property (@(posedge clk) disable iff (!nrst)
        current_mode == m_mode)
        else begin
            err_count = err_count + 1;
            $display("FAILED current_mode: got %h expected %h",
                     $sampled(current_mode), $sampled(m_mode));
        end

    always @(posedge clk) begin
        if (redirect_valid)
            redirect_count <= redirect_count + 1;
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // stimulus helpers
    task automatic csr_access(input csr_pkg::csr_op_t op, input logic [11:0] addr,
                              input logic [31:0] src);
        @(posedge clk);
        csr_valid <= 1'b1;
        csr_op    <= op;
        csr_addr  <= addr;
        csr_src   <= src;
        @(posedge clk);
        csr_valid <= 1'b0;
        access_count++;
    endtask

    // set with zero source reads without changing anything
    task automatic read_csr(input logic [11:0] addr);
        csr_access(csr_pkg::OP_SET, addr, 32'h0);
    endtask

    task automatic wait_redirect();
        int n;
        n = 0;
        @(posedge clk);
        while (!redirect_valid && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!redirect_valid) begin
            err_count++;
            $display("no redirect arrived within 20 cycles of the event");
        end
    endtask

    // exception plus a csr write in the same cycle, which must be dropped
    task automatic raise_exception(input logic [31:0] pc, input logic [30:0] cause,
                                   input logic [31:0] lost_value);
        @(posedge clk);
        exc_valid <= 1'b1;
        exc_pc    <= pc;
        exc_cause <= cause;
        csr_valid <= 1'b1;
        csr_op    <= csr_pkg::OP_WRITE;
        csr_addr  <= `CSR_MSCRATCH;
        csr_src   <= lost_value;
        @(posedge clk);
        exc_valid <= 1'b0;
        csr_valid <= 1'b0;
        wait_redirect();
    endtask

    task automatic pulse_mret();
        @(posedge clk);
        mret_valid <= 1'b1;
        @(posedge clk);
        mret_valid <= 1'b0;
        wait_redirect();
    endtask

    task automatic take_irq(input logic ext, input logic tmr);
        @(posedge clk);
        exc_pc    <= $random(seed);    // interrupted pc
        ext_irq   <= ext;
        timer_irq <= tmr;
        wait_redirect();
        ext_irq   <= 1'b0;
        timer_irq <= 1'b0;
    endtask

    task automatic hold_masked_irq(input logic ext, input logic tmr);
        @(posedge clk);
        ext_irq   <= ext;
        timer_irq <= tmr;
        repeat (10) @(posedge clk);
        ext_irq   <= 1'b0;
        timer_irq <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        logic [31:0]      rnd;
        logic [31:0]      pick;
        csr_pkg::csr_op_t op;

        nrst       = 1'b0;
        csr_valid  = 1'b0;
        csr_op     = csr_pkg::OP_WRITE;
        csr_addr   = '0;
        csr_src    = '0;
        exc_valid  = 1'b0;
        exc_cause  = '0;
        exc_pc     = '0;
        mret_valid = 1'b0;
        ext_irq    = 1'b0;
        timer_irq  = 1'b0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;

        // reset values
        read_csr(`CSR_MSTATUS);
        read_csr(`CSR_MIE);
        read_csr(`CSR_MTVEC);
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MISA);

        for (int i = 0; i < 40; i++) begin
            rnd  = $random(seed);
            pick = $random(seed);
            case (rnd % 3)
                0:       op = csr_pkg::OP_WRITE;
                1:       op = csr_pkg::OP_SET;
                default: op = csr_pkg::OP_CLEAR;
            endcase
            csr_access(op, pick[0] ? `CSR_MTVEC : `CSR_MSCRATCH, $random(seed));
        end

        // read-only and unimplemented space
        csr_access(csr_pkg::OP_WRITE, `CSR_MVENDORID, $random(seed));
        read_csr(`CSR_MVENDORID);
        csr_access(csr_pkg::OP_WRITE, `CSR_MISA, 32'h0);
        read_csr(`CSR_MISA);
        read_csr(12'h7C0);

        // exception taken from M with MIE set and MPP at U
        csr_access(csr_pkg::OP_WRITE, `CSR_MSTATUS, 32'h0000_0008);
        rnd = $random(seed);
        raise_exception($random(seed), {26'b0, rnd[4:0]}, $random(seed));
        read_csr(`CSR_MEPC);
        read_csr(`CSR_MCAUSE);
        read_csr(`CSR_MSTATUS);
        read_csr(`CSR_MSCRATCH);

        // mret into U with MPIE clear and MIE set
        csr_access(csr_pkg::OP_WRITE, `CSR_MSTATUS, 32'h0000_0008);
        pulse_mret();
        read_csr(`CSR_MSTATUS);

        // interrupts, external, timer, then both
        csr_access(csr_pkg::OP_WRITE, `CSR_MIE, 32'h0000_0880);
        csr_access(csr_pkg::OP_WRITE, `CSR_MSTATUS, 32'h0000_1808);
        take_irq(1'b1, 1'b0);
        read_csr(`CSR_MCAUSE);
        csr_access(csr_pkg::OP_WRITE, `CSR_MSTATUS, 32'h0000_1808);
        take_irq(1'b0, 1'b1);
        read_csr(`CSR_MCAUSE);
        csr_access(csr_pkg::OP_WRITE, `CSR_MSTATUS, 32'h0000_1808);
        take_irq(1'b1, 1'b1);
        read_csr(`CSR_MCAUSE);

        // meie clear, then global mie clear
        csr_access(csr_pkg::OP_WRITE, `CSR_MIE, 32'h0000_0080);
        csr_access(csr_pkg::OP_WRITE, `CSR_MSTATUS, 32'h0000_1808);
        hold_masked_irq(1'b1, 1'b0);
        csr_access(csr_pkg::OP_WRITE, `CSR_MIE, 32'h0000_0880);
        csr_access(csr_pkg::OP_WRITE, `CSR_MSTATUS, 32'h0000_1800);
        hold_masked_irq(1'b1, 1'b1);

        repeat (2) @(posedge clk);
        $display("errors: %0d, csr accesses: %0d, redirects: %0d, cycles: %0d",
                 err_count, access_count, redirect_count, cycle_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_unit (
    input  logic                clk,
    input  logic                nrst,
    input  logic                csr_valid,
    input  csr_pkg::csr_op_t    csr_op,
    input  logic [11:0]         csr_addr,
    input  logic [`XLEN-1:0]    csr_src,
    input  logic                exc_valid,
    input  logic [30:0]         exc_cause,
    input  logic [`XLEN-1:0]    exc_pc,
    input  logic                mret_valid,
    input  logic                ext_irq,
    input  logic                timer_irq,
    output logic [`XLEN-1:0]    csr_rdata,
    output logic                csr_illegal,
    output logic                redirect_valid,
    output logic [`XLEN-1:0]    redirect_pc,
    output csr_pkg::mode_t      current_mode
);

    // write path
    logic               wr_en;
    logic [`XLEN-1:0]   wr_data;

    // trap / return path
    logic               trap_take;
    csr_pkg::mcause_t   trap_cause;
    logic [`XLEN-1:0]   trap_epc;
    logic               ret_take;

    // state seen by the trap logic
    logic [`XLEN-1:0]   mtvec;
    logic [`XLEN-1:0]   mepc;
    logic               mie_bit;
    logic               meie;
    logic               mtie;

    csr_op_unit u_op (
        .csr_valid      (csr_valid),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_src        (csr_src),
        .old_value      (csr_rdata),    // read data is the old value
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .csr_illegal    (csr_illegal)
    );

    csr_regfile u_regs (
        .clk            (clk),
        .nrst           (nrst),
        .csr_addr       (csr_addr),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .trap_take      (trap_take),
        .trap_cause     (trap_cause),
        .trap_epc       (trap_epc),
        .ret_take       (ret_take),
        .ext_irq        (ext_irq),
        .timer_irq      (timer_irq),
        .old_value      (csr_rdata),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .mie_bit        (mie_bit),
        .meie           (meie),
        .mtie           (mtie),
        .current_mode   (current_mode)
    );

    trap_ctrl u_trap (
        .clk            (clk),
        .nrst           (nrst),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .mret_valid     (mret_valid),
        .ext_irq        (ext_irq),
        .timer_irq      (timer_irq),
        .mie_bit        (mie_bit),
        .meie           (meie),
        .mtie           (mtie),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .trap_take      (trap_take),
        .trap_cause     (trap_cause),
        .trap_epc       (trap_epc),
        .ret_take       (ret_take),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// File: trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module trap_ctrl (
    input  logic                clk,
    input  logic                nrst,
    input  logic                exc_valid,
    input  logic [30:0]         exc_cause,
    input  logic [`XLEN-1:0]    exc_pc,
    input  logic                mret_valid,
    input  logic                ext_irq,
    input  logic                timer_irq,
    input  logic                mie_bit,
    input  logic                meie,
    input  logic                mtie,
    input  logic [`XLEN-1:0]    mtvec,
    input  logic [`XLEN-1:0]    mepc,
    output logic                trap_take,
    output csr_pkg::mcause_t    trap_cause,
    output logic [`XLEN-1:0]    trap_epc,
    output logic                ret_take,
    output logic                redirect_valid,
    output logic [`XLEN-1:0]    redirect_pc
);

    logic               ext_fire;
    logic               timer_fire;
    logic [`XLEN-1:0]   target_pc;

    // interrupt needs pending, its own enable and global mie
    assign ext_fire   = ext_irq && meie && mie_bit;
    assign timer_fire = timer_irq && mtie && mie_bit;

    // for an interrupt exc_pc is the interrupted pc
    assign trap_epc = exc_pc;

    //////////////////////////////////////////////////////////////////////
    // priority: exception > mret > external > timer
    always_comb begin
        trap_take  = 1'b0;
        ret_take   = 1'b0;
        trap_cause = '0;
        target_pc  = mtvec;
        if (exc_valid) begin
            trap_take       = 1'b1;
            trap_cause.code = exc_cause;
        end else if (mret_valid) begin
            ret_take  = 1'b1;
            target_pc = mepc;
        end else if (ext_fire) begin
            trap_take            = 1'b1;
            trap_cause.interrupt = 1'b1;
            trap_cause.code      = csr_pkg::CAUSE_M_EXT;
        end else if (timer_fire) begin
            trap_take            = 1'b1;
            trap_cause.interrupt = 1'b1;
            trap_cause.code      = csr_pkg::CAUSE_M_TIMER;
        end
    end

    // redirect one cycle after the event
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= trap_take || ret_take;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc <= target_pc;   // target captured at the event
    end

    // the core never retires mret and faults in the same cycle
    a_exc_mret_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(exc_valid && mret_valid))
        else $error("exc_valid and mret_valid high together");

endmodule

`default_nettype wire

// File: csr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_regfile (
    input  logic                clk,
    input  logic                nrst,
    input  logic [11:0]         csr_addr,
    input  logic                wr_en,
    input  logic [`XLEN-1:0]    wr_data,
    input  logic                trap_take,
    input  csr_pkg::mcause_t    trap_cause,
    input  logic [`XLEN-1:0]    trap_epc,
    input  logic                ret_take,
    input  logic                ext_irq,
    input  logic                timer_irq,
    output logic [`XLEN-1:0]    old_value,
    output logic [`XLEN-1:0]    mtvec,
    output logic [`XLEN-1:0]    mepc,
    output logic                mie_bit,
    output logic                meie,
    output logic                mtie,
    output csr_pkg::mode_t      current_mode
);

    // mstatus fields
    logic               status_mie;
    logic               status_mpie;
    csr_pkg::mode_t     status_mpp;

    // mie enables
    logic               meie_q;
    logic               mtie_q;

    logic [`XLEN-1:2]   mtvec_base;     // direct mode only
    logic [`XLEN-1:2]   mepc_base;
    csr_pkg::mcause_t   mcause_q;
    logic [`XLEN-1:0]   mtval_q;
    logic [`XLEN-1:0]   mscratch_q;

    // assembled words
    csr_pkg::mstatus_t  mstatus_w;
    logic [`XLEN-1:0]   mie_w;
    logic [`XLEN-1:0]   mip_w;
    csr_pkg::csr_word_u wr_word;

    always_comb begin
        mstatus_w      = '0;
        mstatus_w.mie  = status_mie;
        mstatus_w.mpie = status_mpie;
        mstatus_w.mpp  = status_mpp;
    end

    assign mie_w = {20'b0, meie_q, 3'b0, mtie_q, 7'b0};
    assign mip_w = {20'b0, ext_irq, 3'b0, timer_irq, 7'b0};    // pending follows the pins

    assign wr_word.raw = wr_data;

    //////////////////////////////////////////////////////////////////////
    // read mux
    always_comb begin
        case (csr_addr)
            `CSR_MISA:      old_value = `MISA_VALUE;
            `CSR_MVENDORID: old_value = '0;
            `CSR_MARCHID:   old_value = '0;
            `CSR_MIMPID:    old_value = '0;
            `CSR_MHARTID:   old_value = '0;
            `CSR_MSTATUS:   old_value = mstatus_w;
            `CSR_MIE:       old_value = mie_w;
            `CSR_MIP:       old_value = mip_w;
            `CSR_MTVEC:     old_value = mtvec;
            `CSR_MEPC:      old_value = mepc;
            `CSR_MCAUSE:    old_value = mcause_q;
            `CSR_MTVAL:     old_value = mtval_q;
            `CSR_MSCRATCH:  old_value = mscratch_q;
            default:        old_value = '0;     // unimplemented
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state update, trap and return take priority over the csr write
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            current_mode <= csr_pkg::M;
            status_mie   <= 1'b0;
            status_mpie  <= 1'b0;
            status_mpp   <= csr_pkg::U;
            meie_q       <= 1'b0;
            mtie_q       <= 1'b0;
            mtvec_base   <= '0;
            mepc_base    <= '0;
            mcause_q     <= '0;
            mtval_q      <= '0;
            mscratch_q   <= '0;
        end else if (trap_take) begin
            mepc_base    <= trap_epc[`XLEN-1:2];
            mcause_q     <= trap_cause;
            status_mpie  <= status_mie;
            status_mie   <= 1'b0;
            status_mpp   <= current_mode;
            current_mode <= csr_pkg::M;
        end else if (ret_take) begin
            status_mie   <= status_mpie;
            status_mpie  <= 1'b1;
            current_mode <= status_mpp;
            status_mpp   <= csr_pkg::U;
        end else if (wr_en) begin
            case (csr_addr)
                `CSR_MSTATUS: begin
                    status_mie  <= wr_word.status.mie;
                    status_mpie <= wr_word.status.mpie;
                    // only U and M exist, anything else lands on M
                    status_mpp  <= (wr_word.status.mpp == csr_pkg::U) ? csr_pkg::U
                                                                      : csr_pkg::M;
                end
                `CSR_MIE: begin
                    meie_q <= wr_data[11];
                    mtie_q <= wr_data[7];
                end
                `CSR_MTVEC:    mtvec_base <= wr_data[`XLEN-1:2];
                `CSR_MEPC:     mepc_base  <= wr_data[`XLEN-1:2];
                `CSR_MCAUSE:   mcause_q   <= wr_word.cause;
                `CSR_MTVAL:    mtval_q    <= wr_data;
                `CSR_MSCRATCH: mscratch_q <= wr_data;
                default: ;                              // mip and the rest ignore writes
            endcase
        end
    end

    assign mtvec   = {mtvec_base, 2'b00};
    assign mepc    = {mepc_base, 2'b00};
    assign mie_bit = status_mie;
    assign meie    = meie_q;
    assign mtie    = mtie_q;

    // trap_ctrl must never grant both in one cycle
    a_trap_ret_exclusive: assert property (@(posedge clk) disable iff (!nrst)
        !(trap_take && ret_take))
        else $error("trap_take and ret_take high together");

    a_mpp_legal: assert property (@(posedge clk) disable iff (!nrst)
        status_mpp inside {csr_pkg::U, csr_pkg::M})
        else $error("mpp holds illegal mode %h", status_mpp);

endmodule

`default_nettype wire

// File: csr_op_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_op_unit (
    input  logic                csr_valid,
    input  csr_pkg::csr_op_t    csr_op,
    input  logic [11:0]         csr_addr,
    input  logic [`XLEN-1:0]    csr_src,
    input  logic [`XLEN-1:0]    old_value,
    output logic                wr_en,
    output logic [`XLEN-1:0]    wr_data,
    output logic                csr_illegal
);

    logic op_known;
    logic read_only;

    // top two address bits 11 mark read-only space
    // misa is fixed in this core and treated the same way
    assign read_only = (csr_addr[11:10] == 2'b11) || (csr_addr == `CSR_MISA);

    //////////////////////////////////////////////////////////////////////
    // read-modify-write value
    always_comb begin
        op_known = 1'b1;
        case (csr_op)
            csr_pkg::OP_WRITE: wr_data = csr_src;
            csr_pkg::OP_SET:   wr_data = old_value | csr_src;
            csr_pkg::OP_CLEAR: wr_data = old_value & ~csr_src;
            default: begin
                wr_data  = old_value;   // unknown op, leave value alone
                op_known = 1'b0;
            end
        endcase
    end

    // set/clear with zero source still counts as a write
    assign csr_illegal = csr_valid && op_known && read_only;
    assign wr_en       = csr_valid && op_known && !read_only;

endmodule

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

    // privilege mode, also the encoding of mstatus.mpp
    typedef enum logic [1:0] {
        U = 2'd0,
        M = 2'd3
    } mode_t;

    // low bits of funct3 for csrrw / csrrs / csrrc
    typedef enum logic [1:0] {
        OP_WRITE = 2'd1,
        OP_SET   = 2'd2,
        OP_CLEAR = 2'd3
    } csr_op_t;

    typedef struct packed {
        logic [18:0] rsv_31_13;
        mode_t       mpp;        // bits 12:11
        logic [2:0]  rsv_10_8;
        logic        mpie;       // bit 7
        logic [2:0]  rsv_6_4;
        logic        mie;        // bit 3
        logic [2:0]  rsv_2_0;
    } mstatus_t;

    typedef struct packed {
        logic        interrupt;
        logic [30:0] code;
    } mcause_t;

    // one csr word, seen raw or through either register layout
    typedef union packed {
        logic [31:0] raw;
        mstatus_t    status;
        mcause_t     cause;
    } csr_word_u;

    // interrupt cause codes
    localparam logic [30:0] CAUSE_M_EXT   = 31'd11;
    localparam logic [30:0] CAUSE_M_TIMER = 31'd7;

endpackage

`default_nettype wire

// File: csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// data path width, rv32 only
`define XLEN 32

//////////////////////////////////////////////////////////////////////
// machine information registers, read-only space
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13
`define CSR_MHARTID     12'hF14

//////////////////////////////////////////////////////////////////////
// machine trap setup
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305

// machine trap handling
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344

// mxl = 1 (rv32), extensions I (bit 8) and U (bit 20)
`define MISA_VALUE      32'h4010_0100

`endif
